/* dv/exec_tb.sv */
`timescale 1ns/1ps

module exec_tb import exec_pkg::*; ();

  typedef struct packed {
    logic        rd_we;
    logic [31:0] rd_data;
    logic        jump;
    logic [31:0] jump_addr;
    logic        ecall;
    logic        ebreak;
    logic        trap_done;
    logic        csr_we;
    logic [31:0] csr_wdata;
  } exp_t;

  logic        clk;
  logic        reset;
  core_state_e state;
  exec_req_t   req;
  logic        rd_we;
  logic [31:0] rd_data;
  logic        jump;
  logic [31:0] jump_addr;
  logic        ecall;
  logic        ebreak;
  logic        trap_done;

  exp_t        exp_now;
  logic        chk_en;
  logic [31:0] seed;
  logic [31:0] csr_model [6];
  logic        step_m;
  priv_mode_e  mode_m;

  tb_clock clk0 (
    .o_clk   (clk),
    .o_reset (reset)
  );

  exec_unit #(
    .RESET_MTVEC (32'h0000_0100),
    .RESET_STVEC (32'h0000_0200)
  ) dut0 (
    .i_clk       (clk),
    .i_reset     (reset),
    .i_state     (state),
    .i_req       (req),
    .o_rd_we     (rd_we),
    .o_rd_data   (rd_data),
    .o_jump      (jump),
    .o_jump_addr (jump_addr),
    .o_ecall     (ecall),
    .o_ebreak    (ebreak),
    .o_trap_done (trap_done)
  );

  function logic [31:0] rand32();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else begin
      $display("Error: time %0t, %s = %h, expected %h", $time, name, got, want);
      $display("Result: FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic int csr_slot(input logic [11:0] addr);
    case (addr)
      CSR_MSTATUS: return 0;
      CSR_SSTATUS: return 1;
      CSR_MEPC:    return 2;
      CSR_SEPC:    return 3;
      CSR_MTVEC:   return 4;
      CSR_STVEC:   return 5;
      default:     return -1; // Unsupported address reads zero
    endcase
  endfunction

  function automatic logic [31:0] csr_get(input logic [11:0] addr);
    int idx;
    idx = csr_slot(addr);
    return (idx < 0) ? 32'h0 : csr_model[idx];
  endfunction

  function automatic void csr_set(input logic [11:0] addr, input logic [31:0] val);
    int idx;
    idx = csr_slot(addr);
    if (idx >= 0) csr_model[idx] = val;
  endfunction

  // Status word after entry into machine or supervisor interrupt
  function automatic logic [31:0] status_entry(input logic [31:0] s, input logic m,
                                               input logic [1:0] mode);
    logic [31:0] n;
    n = s;
    if (m) begin
      n[12:11] = mode; // MPP
      n[7]     = s[3]; // MPIE
      n[3]     = 1'b0;
    end else begin
      n[8] = mode[0];  // SPP
      n[5] = s[1];     // SPIE
      n[1] = 1'b0;
    end
    return n;
  endfunction

  function automatic logic [31:0] div_ref(input logic [31:0] a, input logic [31:0] b,
                                          input logic sgn, input logic rem);
    if (b == 32'h0) return rem ? a : 32'hFFFF_FFFF;
    if (sgn && a == 32'h8000_0000 && b == 32'hFFFF_FFFF) return rem ? 32'h0 : a;
    if (!sgn) return rem ? a % b : a / b;
    return rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
  endfunction

  function automatic exp_t expect_of(input core_state_e st, input exec_req_t r,
                                     input logic [31:0] old, input logic [31:0] tvec,
                                     input logic step);
    exp_t        e;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] zimm;
    logic [31:0] br_off;
    logic [31:0] j_off;
    logic [63:0] p_ss;
    logic [63:0] p_su;
    logic [63:0] p_uu;
    e      = '0;
    w      = r.ir;
    a      = r.a;
    b      = r.b;
    imm_i  = {{20{w[31]}}, w[31:20]};
    imm_u  = {w[31:12], 12'h0};
    zimm   = {27'h0, w[19:15]};
    br_off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    j_off  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    p_ss   = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    p_su   = {{32{a[31]}}, a} * {32'h0, b};
    p_uu   = {32'h0, a} * {32'h0, b};
    if (st == ST_MINT || st == ST_SINT) begin
      e.jump      = step; // Second entry cycle only
      e.jump_addr = tvec;
      e.trap_done = step;
    end else if (st == ST_EXECUTE) begin
      e.rd_we = 1'b1;
      case (r.op)
        OP_ADD:    e.rd_data = a + b;
        OP_SUB:    e.rd_data = a - b;
        OP_SLL:    e.rd_data = a << b[4:0];
        OP_SLT:    e.rd_data = {31'h0, $signed(a) < $signed(b)};
        OP_SLTU:   e.rd_data = {31'h0, a < b};
        OP_XOR:    e.rd_data = a ^ b;
        OP_SRL:    e.rd_data = a >> b[4:0];
        OP_SRA:    e.rd_data = $signed(a) >>> b[4:0];
        OP_OR:     e.rd_data = a | b;
        OP_AND:    e.rd_data = a & b;
        OP_MUL:    e.rd_data = p_uu[31:0];
        OP_MULH:   e.rd_data = p_ss[63:32];
        OP_MULHSU: e.rd_data = p_su[63:32];
        OP_MULHU:  e.rd_data = p_uu[63:32];
        OP_DIV:    e.rd_data = div_ref(a, b, 1'b1, 1'b0);
        OP_DIVU:   e.rd_data = div_ref(a, b, 1'b0, 1'b0);
        OP_REM:    e.rd_data = div_ref(a, b, 1'b1, 1'b1);
        OP_REMU:   e.rd_data = div_ref(a, b, 1'b0, 1'b1);
        OP_ADDI:   e.rd_data = a + imm_i;
        OP_SLTI:   e.rd_data = {31'h0, $signed(a) < $signed(imm_i)};
        OP_SLTIU:  e.rd_data = {31'h0, a < imm_i};
        OP_XORI:   e.rd_data = a ^ imm_i;
        OP_ORI:    e.rd_data = a | imm_i;
        OP_ANDI:   e.rd_data = a & imm_i;
        OP_SLLI:   e.rd_data = a << w[24:20];
        OP_SRLI:   e.rd_data = a >> w[24:20];
        OP_SRAI:   e.rd_data = $signed(a) >>> w[24:20];
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
          e.rd_we     = 1'b0;
          e.jump_addr = r.pc + br_off;
          if (r.op == OP_BEQ) e.jump = (a == b);
          if (r.op == OP_BNE) e.jump = (a != b);
          if (r.op == OP_BLT) e.jump = ($signed(a) < $signed(b));
          if (r.op == OP_BGE) e.jump = !($signed(a) < $signed(b));
          if (r.op == OP_BLTU) e.jump = (a < b);
          if (r.op == OP_BGEU) e.jump = !(a < b);
        end
        OP_JAL: begin
          e.rd_data   = r.pc + 32'd4;
          e.jump      = 1'b1;
          e.jump_addr = r.pc + j_off;
        end
        OP_JALR: begin
          e.rd_data   = r.pc + 32'd4;
          e.jump      = 1'b1;
          e.jump_addr = a + imm_i;
        end
        OP_LUI:    e.rd_data = imm_u;
        OP_AUIPC:  e.rd_data = r.pc + imm_u;
        OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI: begin
          e.rd_data = old;
          e.csr_we  = 1'b1;
          if (r.op == OP_CSRRW) e.csr_wdata = a;
          if (r.op == OP_CSRRS) e.csr_wdata = old | a;
          if (r.op == OP_CSRRC) e.csr_wdata = old & ~a;
          if (r.op == OP_CSRRWI) e.csr_wdata = zimm;
          if (r.op == OP_CSRRSI) e.csr_wdata = old | zimm;
          if (r.op == OP_CSRRCI) e.csr_wdata = old & ~zimm;
        end
        OP_ECALL: begin
          e.rd_we = 1'b0;
          e.ecall = 1'b1;
        end
        OP_EBREAK: begin
          e.rd_we  = 1'b0;
          e.ebreak = 1'b1;
        end
        default:   e.rd_we = 1'b0; // Accepted no-ops
      endcase
    end
    return e;
  endfunction

  function automatic exec_req_t mk_req(input alu_op_e op, input logic [31:0] ir,
                                       input logic [31:0] a, input logic [31:0] b,
                                       input logic [31:0] pc);
    exec_req_t r;
    r.op = op;
    r.ir = ir;
    r.a  = a;
    r.b  = b;
    r.pc = pc;
    return r;
  endfunction

  function automatic exec_req_t rand_req(input alu_op_e op);
    return mk_req(op, rand32(), rand32(), rand32(), rand32() & 32'hFFFF_FFFC);
  endfunction

  function automatic logic [31:0] csr_ir(input logic [11:0] addr, input logic [4:0] zimm);
    return {addr, zimm, 3'b010, 5'd1, 7'h73};
  endfunction

  // No-op whose immediate field names a live CSR
  function automatic exec_req_t nop_req(input alu_op_e op, input logic [11:0] addr);
    return mk_req(op, csr_ir(addr, 5'h1F), rand32(), rand32(), rand32());
  endfunction

  // Drives one cycle and updates the CSR and privilege model
  task automatic apply(input core_state_e st, input exec_req_t r);
    exp_t        e;
    logic [31:0] w;
    logic [31:0] tvec;
    logic        is_m;
    w    = r.ir;
    is_m = (st == ST_MINT);
    tvec = is_m ? csr_get(CSR_MTVEC) : csr_get(CSR_STVEC);
    e    = expect_of(st, r, csr_get(w[31:20]), tvec, step_m);
    @(posedge clk);
    state   <= st;
    req     <= r;
    exp_now <= e;
    chk_en  <= !(st == ST_EXECUTE && r.op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU});
    if (e.csr_we) csr_set(w[31:20], e.csr_wdata);
    if (st == ST_MINT || st == ST_SINT) begin
      if (!step_m) begin
        if (is_m) csr_set(CSR_MSTATUS, status_entry(csr_get(CSR_MSTATUS), 1'b1, mode_m));
        else csr_set(CSR_SSTATUS, status_entry(csr_get(CSR_SSTATUS), 1'b0, mode_m));
      end else begin
        csr_set(is_m ? CSR_MEPC : CSR_SEPC, r.pc);
        mode_m = is_m ? PRIV_MACHINE : PRIV_SUPERVISOR;
      end
      step_m = !step_m;
    end else begin
      step_m = 1'b0;
    end
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (reset !== 1'b0) begin
      if (n == 50) stop_run("Reset was never released");
      @(posedge clk);
      n++;
    end
  endtask

  task automatic run_div(input alu_op_e op, input logic [31:0] a, input logic [31:0] b);
    int cycles;
    apply(ST_EXECUTE, mk_req(op, rand32(), a, b, rand32()));
    cycles = 0;
    @(negedge clk);
    while (rd_we !== 1'b1) begin
      if (cycles == 60) stop_run("Divide result never arrived");
      @(negedge clk);
      cycles++;
    end
    check_val("divide latency", cycles, 33);
    check_val("o_rd_data", rd_data, exp_now.rd_data);
  endtask

  task automatic csr_op(input alu_op_e op, input logic [11:0] addr, input logic [31:0] a,
                        input logic [4:0] zimm);
    apply(ST_EXECUTE, mk_req(op, csr_ir(addr, zimm), a, rand32(), rand32()));
  endtask

  task automatic read_csr(input logic [11:0] addr, output logic [31:0] val);
    csr_op(OP_CSRRS, addr, 32'h0, 5'd0);
    @(negedge clk);
    val = rd_data;
  endtask

  task automatic enter_trap(input core_state_e st, input logic [31:0] pc);
    exec_req_t r;
    r = mk_req(OP_ADD, rand32(), rand32(), rand32(), pc);
    apply(st, r);
    apply(st, r);
    apply(ST_FETCH, r);
  endtask

  always @(negedge clk) begin
    if (chk_en) begin
      check_val("o_rd_we", {31'h0, rd_we}, {31'h0, exp_now.rd_we});
      if (exp_now.rd_we) check_val("o_rd_data", rd_data, exp_now.rd_data);
      check_val("o_jump", {31'h0, jump}, {31'h0, exp_now.jump});
      if (exp_now.jump) check_val("o_jump_addr", jump_addr, exp_now.jump_addr);
      check_val("o_ecall", {31'h0, ecall}, {31'h0, exp_now.ecall});
      check_val("o_ebreak", {31'h0, ebreak}, {31'h0, exp_now.ebreak});
      check_val("o_trap_done", {31'h0, trap_done}, {31'h0, exp_now.trap_done});
    end
  end

  initial begin
    int          k;
    logic [31:0] pc;
    logic [31:0] val;
    logic [31:0] x;
    state     = ST_FETCH;
    req       = '0;
    chk_en    = 1'b0;
    exp_now   = '0;
    seed      = 32'h5a96_6cd2;
    step_m    = 1'b0;
    mode_m    = PRIV_MACHINE;
    csr_model = '{32'h0, 32'h0, 32'h0, 32'h0, 32'h0000_0100, 32'h0000_0200};
    wait_reset();
    apply(ST_FETCH, '0); // Quiet outputs after reset

    for (k = 0; k <= 26; k++) begin
      if (k < 14 || k > 17) repeat (6) apply(ST_EXECUTE, rand_req(alu_op_e'(k)));
    end
    repeat (6) apply(ST_EXECUTE, rand_req(OP_LUI));
    repeat (6) apply(ST_EXECUTE, rand_req(OP_AUIPC));
    apply(ST_EXECUTE, mk_req(OP_MULH, 32'h0, 32'h8000_0000, 32'h8000_0000, 32'h0));
    apply(ST_EXECUTE, mk_req(OP_MULHSU, 32'h0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0));
    apply(ST_EXECUTE, mk_req(OP_MULHU, 32'h0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0));

    for (k = OP_BEQ; k <= OP_BGEU; k++) begin
      repeat (4) apply(ST_EXECUTE, rand_req(alu_op_e'(k)));
      x = rand32();
      apply(ST_EXECUTE, mk_req(alu_op_e'(k), rand32(), x, x, rand32() & 32'hFFFF_FFFC));
    end
    repeat (4) apply(ST_EXECUTE, rand_req(OP_JAL));
    repeat (4) apply(ST_EXECUTE, rand_req(OP_JALR));

    for (k = OP_DIV; k <= OP_REMU; k++) begin
      repeat (3) run_div(alu_op_e'(k), rand32(), rand32());
      run_div(alu_op_e'(k), rand32(), 32'h0);
      run_div(alu_op_e'(k), 32'hFFFF_FFF9, 32'h2); // Small negative dividend
    end
    run_div(OP_DIV, 32'h8000_0000, 32'hFFFF_FFFF);
    run_div(OP_REM, 32'h8000_0000, 32'hFFFF_FFFF);
    apply(ST_FETCH, '0);

    csr_op(OP_CSRRW, CSR_MTVEC, rand32() & 32'hFFFF_FFFC, 5'd0);
    csr_op(OP_CSRRS, CSR_MTVEC, 32'h0, 5'd0);
    csr_op(OP_CSRRC, CSR_MTVEC, 32'h0000_00F0, 5'd0);
    csr_op(OP_CSRRWI, CSR_MEPC, 32'h0, 5'h15);
    csr_op(OP_CSRRSI, CSR_MEPC, 32'h0, 5'h0A);
    csr_op(OP_CSRRCI, CSR_MEPC, 32'h0, 5'h03);
    csr_op(OP_CSRRS, CSR_MEPC, 32'h0, 5'd0);
    csr_op(OP_CSRRW, 12'h7C0, rand32(), 5'd0);
    csr_op(OP_CSRRS, 12'h7C0, 32'h0, 5'd0);

    csr_op(OP_CSRRW, CSR_MSTATUS, 32'h0000_0008, 5'd0); // MIE set
    apply(ST_FETCH, '0);
    pc = rand32() & 32'hFFFF_FFFC;
    enter_trap(ST_MINT, pc);
    read_csr(CSR_MSTATUS, val);
    check_val("mstatus.MPP", {30'h0, val[12:11]}, {30'h0, PRIV_MACHINE});
    check_val("mstatus.MIE", {31'h0, val[3]}, 32'h0);
    check_val("mstatus.MPIE", {31'h0, val[7]}, 32'h1);
    read_csr(CSR_MEPC, val);
    check_val("mepc", val, pc);

    csr_op(OP_CSRRW, CSR_SSTATUS, 32'h0000_0002, 5'd0); // SIE set
    apply(ST_FETCH, '0);
    pc = rand32() & 32'hFFFF_FFFC;
    enter_trap(ST_SINT, pc);
    read_csr(CSR_SSTATUS, val);
    check_val("sstatus.SPP", {31'h0, val[8]}, 32'h1);
    check_val("sstatus.SIE", {31'h0, val[1]}, 32'h0);
    check_val("sstatus.SPIE", {31'h0, val[5]}, 32'h1);
    read_csr(CSR_SEPC, val);
    check_val("sepc", val, pc);

    // Mode left by each entry shows up in the next MPP
    pc = rand32() & 32'hFFFF_FFFC;
    enter_trap(ST_MINT, pc);
    read_csr(CSR_MSTATUS, val);
    check_val("mstatus.MPP", {30'h0, val[12:11]}, {30'h0, PRIV_SUPERVISOR});
    enter_trap(ST_MINT, pc);
    read_csr(CSR_MSTATUS, val);
    check_val("mstatus.MPP", {30'h0, val[12:11]}, {30'h0, PRIV_MACHINE});

    apply(ST_EXECUTE, rand_req(OP_ECALL));
    apply(ST_FETCH, '0);
    apply(ST_EXECUTE, rand_req(OP_EBREAK));
    apply(ST_FETCH, '0);
    for (k = OP_LB; k <= OP_SW; k++) begin
      apply(ST_EXECUTE, nop_req(alu_op_e'(k), CSR_MTVEC));
    end
    apply(ST_EXECUTE, nop_req(OP_FENCE, CSR_MEPC));
    apply(ST_EXECUTE, nop_req(OP_FENCE_I, CSR_MEPC));
    apply(ST_EXECUTE, nop_req(OP_WFI, CSR_MEPC));
    csr_op(OP_CSRRS, CSR_MTVEC, 32'h0, 5'd0); // Unchanged by the no-ops
    csr_op(OP_CSRRS, CSR_MEPC, 32'h0, 5'd0);
    apply(ST_FETCH, '0);
    @(negedge clk);

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int RESET_CYCLES = 10
) (
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk; // 4 ns period
  end

  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_reset <= 1'b0;
  end

endmodule

/* files.f */
rtl/exec_pkg.sv
rtl/int_alu.sv
rtl/div_unit.sv
rtl/csr_file.sv
rtl/trap_entry.sv
rtl/exec_unit.sv
dv/tb_clock.sv
dv/exec_tb.sv

/* rtl/csr_file.sv */
`timescale 1ns/1ps

module csr_file import exec_pkg::*; #(
  parameter logic [31:0] RESET_MTVEC = 32'h0,
  parameter logic [31:0] RESET_STVEC = 32'h0
) (
  input  logic        i_clk,
  input  logic        i_reset,
  input  logic [11:0] i_raddr,
  input  csr_wr_t     i_alu_wr,
  input  csr_wr_t     i_trap_wr,
  output logic [31:0] o_rdata,
  output trap_csr_t   o_trap_csr
);

  logic [31:0] mstatus;
  logic [31:0] sstatus;
  logic [31:0] mepc;
  logic [31:0] sepc;
  logic [31:0] mtvec;
  logic [31:0] stvec;
  csr_wr_t     wr;

  assign wr = i_trap_wr.we ? i_trap_wr : i_alu_wr; // Trap port first

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      mstatus <= '0;
      sstatus <= '0;
      mepc    <= '0;
      sepc    <= '0;
      mtvec   <= RESET_MTVEC;
      stvec   <= RESET_STVEC;
    end else if (wr.we) begin
      case (wr.addr)
        CSR_MSTATUS: mstatus <= wr.data;
        CSR_SSTATUS: sstatus <= wr.data;
        CSR_MEPC:    mepc    <= wr.data;
        CSR_SEPC:    sepc    <= wr.data;
        CSR_MTVEC:   mtvec   <= wr.data;
        CSR_STVEC:   stvec   <= wr.data;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (i_raddr)
      CSR_MSTATUS: o_rdata = mstatus;
      CSR_SSTATUS: o_rdata = sstatus;
      CSR_MEPC:    o_rdata = mepc;
      CSR_SEPC:    o_rdata = sepc;
      CSR_MTVEC:   o_rdata = mtvec;
      CSR_STVEC:   o_rdata = stvec;
      default:     o_rdata = '0;
    endcase
  end

  assign o_trap_csr = '{mstatus: mstatus, sstatus: sstatus, mtvec: mtvec, stvec: stvec};

  // ALU and trap sequencer own disjoint core states
  a_one_writer: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_alu_wr.we && i_trap_wr.we));

endmodule

/* rtl/div_unit.sv */
`timescale 1ns/1ps

module div_unit (
  input  logic        i_clk,
  input  logic        i_reset,
  input  logic        i_start,
  input  logic        i_signed,
  input  logic        i_abort,
  input  logic [31:0] i_dividend,
  input  logic [31:0] i_divisor,
  output logic        o_done,
  output logic [31:0] o_quot,
  output logic [31:0] o_rem
);

  localparam logic [1:0] PH_IDLE = 2'd0;
  localparam logic [1:0] PH_RUN  = 2'd1;
  localparam logic [1:0] PH_FIX  = 2'd2;
  localparam logic [1:0] PH_DONE = 2'd3;

  logic [1:0]  phase;
  logic [4:0]  count;
  logic [31:0] rem_q;
  logic [31:0] quo_q;
  logic [31:0] dvs_q;
  logic        neg_quo;
  logic        neg_rem;
  logic        start_fire;
  logic [31:0] mag_a;
  logic [31:0] mag_b;
  logic [31:0] in_rem;
  logic [31:0] in_quo;
  logic [31:0] in_dvs;
  logic [32:0] shifted;
  logic [32:0] diff;
  logic        fits;

  assign start_fire = i_start && !i_abort && (phase == PH_IDLE);
  assign mag_a = (i_signed && i_dividend[31]) ? -i_dividend : i_dividend;
  assign mag_b = (i_signed && i_divisor[31]) ? -i_divisor : i_divisor;

  // First step runs straight off the operands in the start cycle
  assign in_rem = (phase == PH_RUN) ? rem_q : '0;
  assign in_quo = (phase == PH_RUN) ? quo_q : mag_a;
  assign in_dvs = (phase == PH_RUN) ? dvs_q : mag_b;

  assign shifted = {in_rem, in_quo[31]};
  assign diff    = shifted - {1'b0, in_dvs};
  assign fits    = (shifted >= {1'b0, in_dvs}); // Zero divisor always fits

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      phase <= PH_IDLE;
      count <= '0;
    end else begin
      case (phase)
        PH_IDLE: begin
          if (start_fire) begin
            phase <= PH_RUN;
            count <= 5'd1;
          end
        end
        PH_RUN: begin
          count <= count + 5'd1;
          if (i_abort) phase <= PH_IDLE;
          else if (count == 5'd31) phase <= PH_FIX; // Step 32 this cycle
        end
        PH_FIX:  phase <= i_abort ? PH_IDLE : PH_DONE;
        default: phase <= PH_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (start_fire || phase == PH_RUN) begin
      rem_q <= fits ? diff[31:0] : shifted[31:0];
      quo_q <= {in_quo[30:0], fits};
    end
    if (start_fire) begin
      dvs_q   <= mag_b;
      neg_quo <= i_signed && (i_dividend[31] ^ i_divisor[31]) && (i_divisor != '0);
      neg_rem <= i_signed && i_dividend[31];
    end
    if (phase == PH_FIX) begin
      quo_q <= neg_quo ? -quo_q : quo_q;
      rem_q <= neg_rem ? -rem_q : rem_q;
    end
  end

  assign o_done = (phase == PH_DONE);
  assign o_quot = quo_q;
  assign o_rem  = rem_q;

  // Remainder magnitude ends below the divisor
  a_rem_below_divisor: assert property (@(posedge i_clk) disable iff (i_reset)
    (phase == PH_FIX) |-> (dvs_q == '0) || (rem_q < dvs_q));

endmodule

/* rtl/exec_pkg.sv */
package exec_pkg;

  typedef enum logic [5:0] {
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA,           // 0
    OP_OR, OP_AND, OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_DIV, OP_DIVU,      // 8
    OP_REM, OP_REMU, OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,     // 16
    OP_SLLI, OP_SRLI, OP_SRAI, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,            // 24
    OP_SB, OP_SH, OP_SW, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU,              // 32
    OP_BGEU, OP_JAL, OP_JALR, OP_LUI, OP_AUIPC, OP_CSRRW, OP_CSRRS, OP_CSRRC,  // 40
    OP_CSRRWI, OP_CSRRSI, OP_CSRRCI, OP_FENCE, OP_FENCE_I, OP_ECALL,           // 48
    OP_EBREAK, OP_URET, OP_SRET, OP_MRET, OP_WFI, OP_SFENCE_VMA                // 54
  } alu_op_e;

  typedef enum logic [1:0] {
    ST_FETCH   = 2'd0,
    ST_EXECUTE = 2'd1,
    ST_MINT    = 2'd2,
    ST_SINT    = 2'd3
  } core_state_e;

  typedef enum logic [1:0] {
    PRIV_USER       = 2'b00,
    PRIV_SUPERVISOR = 2'b01,
    PRIV_MACHINE    = 2'b11
  } priv_mode_e;

  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_SSTATUS = 12'h100;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_SEPC    = 12'h141;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_STVEC   = 12'h105;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_ut_t;

  typedef union packed {
    instr_i_t  i_view;
    instr_ut_t u_view;
  } instr_u;

  typedef struct packed {
    alu_op_e     op;
    instr_u      ir;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pc;
  } exec_req_t;

  typedef struct packed {
    logic        we;
    logic [11:0] addr;
    logic [31:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic [31:0] mstatus;
    logic [31:0] sstatus;
    logic [31:0] mtvec;
    logic [31:0] stvec;
  } trap_csr_t;

endpackage

/* rtl/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit import exec_pkg::*; #(
  parameter logic [31:0] RESET_MTVEC = 32'h0000_0100,
  parameter logic [31:0] RESET_STVEC = 32'h0000_0200
) (
  input  logic        i_clk,
  input  logic        i_reset,
  input  core_state_e i_state,
  input  exec_req_t   i_req,
  output logic        o_rd_we,
  output logic [31:0] o_rd_data,
  output logic        o_jump,
  output logic [31:0] o_jump_addr,
  output logic        o_ecall,
  output logic        o_ebreak,
  output logic        o_trap_done
);

  csr_wr_t     alu_csr_wr;
  csr_wr_t     trap_csr_wr;
  trap_csr_t   trap_csr;
  logic [31:0] csr_rdata;
  logic        div_start;
  logic        div_signed;
  logic        div_abort;
  logic        div_done;
  logic [31:0] div_quot;
  logic [31:0] div_rem;
  logic        trap_jump;
  logic [31:0] trap_addr;

  assign div_abort = (i_state != ST_EXECUTE); // Leaving EXECUTE drops the divide

  int_alu alu0 (
    .i_state      (i_state),
    .i_req        (i_req),
    .i_csr_rdata  (csr_rdata),
    .i_div_done   (div_done),
    .i_div_quot   (div_quot),
    .i_div_rem    (div_rem),
    .i_trap_jump  (trap_jump),
    .i_trap_addr  (trap_addr),
    .o_csr_wr     (alu_csr_wr),
    .o_div_start  (div_start),
    .o_div_signed (div_signed),
    .o_rd_we      (o_rd_we),
    .o_rd_data    (o_rd_data),
    .o_jump       (o_jump),
    .o_jump_addr  (o_jump_addr),
    .o_ecall      (o_ecall),
    .o_ebreak     (o_ebreak)
  );

  div_unit div0 (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_start    (div_start),
    .i_signed   (div_signed),
    .i_abort    (div_abort),
    .i_dividend (i_req.a),
    .i_divisor  (i_req.b),
    .o_done     (div_done),
    .o_quot     (div_quot),
    .o_rem      (div_rem)
  );

  csr_file #(
    .RESET_MTVEC (RESET_MTVEC),
    .RESET_STVEC (RESET_STVEC)
  ) csr0 (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_raddr    (i_req.ir.i_view.imm12),
    .i_alu_wr   (alu_csr_wr),
    .i_trap_wr  (trap_csr_wr),
    .o_rdata    (csr_rdata),
    .o_trap_csr (trap_csr)
  );

  trap_entry trap0 (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_state     (i_state),
    .i_pc        (i_req.pc),
    .i_trap_csr  (trap_csr),
    .o_csr_wr    (trap_csr_wr),
    .o_jump      (trap_jump),
    .o_jump_addr (trap_addr),
    .o_done      (o_trap_done)
  );

endmodule

/* rtl/int_alu.sv */
`timescale 1ns/1ps

module int_alu import exec_pkg::*; (
  input  core_state_e i_state,
  input  exec_req_t   i_req,
  input  logic [31:0] i_csr_rdata,
  input  logic        i_div_done,
  input  logic [31:0] i_div_quot,
  input  logic [31:0] i_div_rem,
  input  logic        i_trap_jump,
  input  logic [31:0] i_trap_addr,
  output csr_wr_t     o_csr_wr,
  output logic        o_div_start,
  output logic        o_div_signed,
  output logic        o_rd_we,
  output logic [31:0] o_rd_data,
  output logic        o_jump,
  output logic [31:0] o_jump_addr,
  output logic        o_ecall,
  output logic        o_ebreak
);

  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_u;
  logic [31:0] imm_csr;
  logic [31:0] br_off;
  logic [31:0] jal_off;
  logic [63:0] prod_ss;
  logic [63:0] prod_uu;
  logic signed [64:0] prod_su;
  logic is_div;

  assign a       = i_req.a;
  assign b       = i_req.b;
  assign imm_i   = {{20{i_req.ir.i_view.imm12[11]}}, i_req.ir.i_view.imm12};
  assign imm_u   = {i_req.ir.u_view.imm20, 12'b0};
  assign imm_csr = {27'b0, i_req.ir.i_view.rs1}; // zimm sits in the rs1 field
  assign br_off  = {{19{i_req.ir.i_view.imm12[11]}}, i_req.ir.i_view.imm12[11],
                    i_req.ir.i_view.rd[0], i_req.ir.i_view.imm12[10:5],
                    i_req.ir.i_view.rd[4:1], 1'b0};
  assign jal_off = {{11{i_req.ir.u_view.imm20[19]}}, i_req.ir.u_view.imm20[19],
                    i_req.ir.u_view.imm20[7:0], i_req.ir.u_view.imm20[8],
                    i_req.ir.u_view.imm20[18:9], 1'b0};

  assign prod_ss = $signed(a) * $signed(b);
  assign prod_uu = a * b;
  assign prod_su = $signed({a[31], a}) * $signed({1'b0, b}); // MULHSU

  assign is_div = (i_req.op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU});
  assign o_div_start  = (i_state == ST_EXECUTE) && is_div;
  assign o_div_signed = (i_req.op == OP_DIV) || (i_req.op == OP_REM);

  always_comb begin
    o_csr_wr      = '0;
    o_csr_wr.addr = i_req.ir.i_view.imm12;
    o_rd_we       = 1'b0;
    o_rd_data     = '0;
    o_jump        = 1'b0;
    o_jump_addr   = i_req.pc + br_off;
    o_ecall       = 1'b0;
    o_ebreak      = 1'b0;
    if (i_state == ST_MINT || i_state == ST_SINT) begin
      o_jump      = i_trap_jump;
      o_jump_addr = i_trap_addr;
    end else if (i_state == ST_EXECUTE) begin
      o_rd_we = 1'b1;
      case (i_req.op)
        OP_ADD:    o_rd_data = a + b;
        OP_SUB:    o_rd_data = a - b;
        OP_SLL:    o_rd_data = a << b[4:0];
        OP_SLT:    o_rd_data = {31'b0, $signed(a) < $signed(b)};
        OP_SLTU:   o_rd_data = {31'b0, a < b};
        OP_XOR:    o_rd_data = a ^ b;
        OP_SRL:    o_rd_data = a >> b[4:0];
        OP_SRA:    o_rd_data = $signed(a) >>> b[4:0];
        OP_OR:     o_rd_data = a | b;
        OP_AND:    o_rd_data = a & b;
        OP_MUL:    o_rd_data = prod_ss[31:0];
        OP_MULH:   o_rd_data = prod_ss[63:32];
        OP_MULHSU: o_rd_data = prod_su[63:32];
        OP_MULHU:  o_rd_data = prod_uu[63:32];
        OP_DIV, OP_DIVU: begin
          o_rd_we   = i_div_done;
          o_rd_data = i_div_quot;
        end
        OP_REM, OP_REMU: begin
          o_rd_we   = i_div_done;
          o_rd_data = i_div_rem;
        end
        OP_ADDI:   o_rd_data = a + imm_i;
        OP_SLTI:   o_rd_data = {31'b0, $signed(a) < $signed(imm_i)};
        OP_SLTIU:  o_rd_data = {31'b0, a < imm_i};
        OP_XORI:   o_rd_data = a ^ imm_i;
        OP_ORI:    o_rd_data = a | imm_i;
        OP_ANDI:   o_rd_data = a & imm_i;
        OP_SLLI:   o_rd_data = a << imm_i[4:0];
        OP_SRLI:   o_rd_data = a >> imm_i[4:0];
        OP_SRAI:   o_rd_data = $signed(a) >>> imm_i[4:0];
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
          o_rd_we = 1'b0;
          case (i_req.op)
            OP_BEQ:  o_jump = (a == b);
            OP_BNE:  o_jump = (a != b);
            OP_BLT:  o_jump = ($signed(a) < $signed(b));
            OP_BGE:  o_jump = ($signed(a) >= $signed(b));
            OP_BLTU: o_jump = (a < b);
            default: o_jump = (a >= b);
          endcase
        end
        OP_JAL, OP_JALR: begin
          o_jump      = 1'b1;
          o_jump_addr = (i_req.op == OP_JAL) ? i_req.pc + jal_off : a + imm_i;
          o_rd_data   = i_req.pc + 32'd4; // Link address
        end
        OP_LUI:    o_rd_data = imm_u;
        OP_AUIPC:  o_rd_data = i_req.pc + imm_u;
        OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI: begin
          o_rd_data   = i_csr_rdata; // Old value to rd
          o_csr_wr.we = 1'b1;
          case (i_req.op)
            OP_CSRRW:  o_csr_wr.data = a;
            OP_CSRRS:  o_csr_wr.data = i_csr_rdata | a;
            OP_CSRRC:  o_csr_wr.data = i_csr_rdata & ~a;
            OP_CSRRWI: o_csr_wr.data = imm_csr;
            OP_CSRRSI: o_csr_wr.data = i_csr_rdata | imm_csr;
            default:   o_csr_wr.data = i_csr_rdata & ~imm_csr;
          endcase
        end
        OP_ECALL: begin
          o_rd_we = 1'b0;
          o_ecall = 1'b1;
        end
        OP_EBREAK: begin
          o_rd_we  = 1'b0;
          o_ebreak = 1'b1;
        end
        default:   o_rd_we = 1'b0; // Loads, stores, fences, xRET, WFI
      endcase
    end
  end

endmodule

/* rtl/trap_entry.sv */
`timescale 1ns/1ps

module trap_entry import exec_pkg::*; (
  input  logic        i_clk,
  input  logic        i_reset,
  input  core_state_e i_state,
  input  logic [31:0] i_pc,
  input  trap_csr_t   i_trap_csr,
  output csr_wr_t     o_csr_wr,
  output logic        o_jump,
  output logic [31:0] o_jump_addr,
  output logic        o_done
);

  logic        step;
  priv_mode_e  mode;
  logic        is_int;
  logic        is_m;
  logic [31:0] new_mstatus;
  logic [31:0] new_sstatus;

  assign is_int = (i_state == ST_MINT) || (i_state == ST_SINT);
  assign is_m   = (i_state == ST_MINT);

  // MPP <= mode, MPIE <= MIE, MIE <= 0
  assign new_mstatus = {i_trap_csr.mstatus[31:13], mode, i_trap_csr.mstatus[10:8],
                        i_trap_csr.mstatus[3], i_trap_csr.mstatus[6:4], 1'b0,
                        i_trap_csr.mstatus[2:0]};
  // SPP <= mode[0], SPIE <= SIE, SIE <= 0
  assign new_sstatus = {i_trap_csr.sstatus[31:9], mode[0], i_trap_csr.sstatus[7:6],
                        i_trap_csr.sstatus[1], i_trap_csr.sstatus[4:2], 1'b0,
                        i_trap_csr.sstatus[0]};

  always_comb begin
    o_csr_wr.we = is_int;
    if (step) begin
      o_csr_wr.addr = is_m ? CSR_MEPC : CSR_SEPC;
      o_csr_wr.data = i_pc;
    end else begin
      o_csr_wr.addr = is_m ? CSR_MSTATUS : CSR_SSTATUS;
      o_csr_wr.data = is_m ? new_mstatus : new_sstatus;
    end
  end

  assign o_jump      = is_int && step;
  assign o_jump_addr = is_m ? i_trap_csr.mtvec : i_trap_csr.stvec;
  assign o_done      = is_int && step;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      step <= 1'b0;
      mode <= PRIV_MACHINE;
    end else begin
      step <= is_int && !step;
      if (is_int && step) mode <= is_m ? PRIV_MACHINE : PRIV_SUPERVISOR;
    end
  end

  // Sequencer must hold the interrupt state for both steps
  a_step_in_int: assert property (@(posedge i_clk) disable iff (i_reset)
    step |-> is_int);

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module exec_tb -f files.f -o exec_sim

# The simulator exits non-zero on $fatal, so the log decides the result
./obj_dir/exec_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Result: PASSED" sim.log; then
  exit 0
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi
